// ==== hw/cpuPkg.sv ====
package cpuPkg;

  typedef logic [31:0] word_t;   // Data word
  typedef logic [31:0] addr_t;   // Byte address, always word aligned
  typedef logic [7:0]  regIdx_t; // Register field as encoded

  // Opcode byte values, numbered from 1
  typedef enum logic [7:0] {
    MovRC = 8'd1,
    MovRR,
    AddRRR,
    AddRRC,
    SubRRR,
    ShlRRR,
    ShrRRR,
    IncR,
    DecR,
    CmpRC,
    JmpC,
    JeC,
    JneC,
    JzRC,
    MovRdRo,
    MovdRoR,
    PushR,
    PopR,
    CallR,
    Ret,
    DoutR,
    Stall
  } opcode_e;

  typedef enum logic [3:0] {
    fetchReq,  // Start instruction read
    fetchWait,
    decode,    // Operands get registered here
    wordReq,   // Constant word read
    wordWait,
    memReq,    // Data read or write
    memWait,
    writeback,
    halted     // Parked until reset
  } seqState_e;

  typedef enum logic [2:0] {
    none,
    load,
    store,
    push,
    pop,
    call,
    ret
  } memKind_e;

  typedef struct packed {
    opcode_e  opcode;
    regIdx_t  regA;      // Byte 1
    regIdx_t  regB;      // Byte 2
    regIdx_t  regC;      // Byte 3
    word_t    constWord; // Second word of 8-byte forms
    logic     needsWord;
    memKind_e memKind;
  } instr_t;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t datW;
  } wbReq_t;

  typedef struct packed {
    logic  ack;
    word_t datR;
  } wbRsp_t;

  typedef struct packed {
    logic    destWrEn;
    regIdx_t destIdx;
    word_t   destData;
    logic    flagWrEn;
    word_t   flagData;  // Bit 0 equal, bit 1 less, bit 2 greater
    word_t   spDelta;   // Two's complement step for r0
    addr_t   nextIp;
    addr_t   memAddr;
    word_t   storeData; // Also carries the DoutR value
    logic    halt;
  } exeOut_t;

endpackage

// ==== hw/busMaster.sv ====
`timescale 1ns/10ps

module busMaster (
  input  logic           clk,
  input  logic           reset,
  input  logic           reqStart, // One-cycle request from sequencer
  input  cpuPkg::addr_t  reqAddr,
  input  logic           reqWrite,
  input  cpuPkg::word_t  reqData,
  output cpuPkg::wbReq_t wbOut,
  input  cpuPkg::wbRsp_t wbIn,
  output logic           reqDone,  // Pulse after the ack edge
  output cpuPkg::word_t  readWord  // Last read data, held
);

  logic          cycReg;
  logic          weReg;
  cpuPkg::addr_t adrReg;
  cpuPkg::word_t datWReg;
  logic          ackSeen;

  assign ackSeen = cycReg && wbIn.ack; // Ack only counts inside a cycle

  // Classic mode, stb follows cyc
  assign wbOut = '{cyc: cycReg, stb: cycReg, we: weReg, adr: adrReg, datW: datWReg};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cycReg  <= 1'b0;
      weReg   <= 1'b0;
      reqDone <= 1'b0;
    end else begin
      reqDone <= ackSeen;
      if (ackSeen) begin
        cycReg <= 1'b0; // Release the cycle after ack
        weReg  <= 1'b0;
      end else if (reqStart) begin
        cycReg <= 1'b1;
        weReg  <= reqWrite;
      end
    end
  end

  // Address and data stay put while waiting
  always_ff @(posedge clk) begin
    if (reqStart && !cycReg) begin
      adrReg  <= reqAddr;
      datWReg <= reqData;
    end
    if (ackSeen && !weReg) readWord <= wbIn.datR; // Capture reads only
  end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/10ps

module registerFile #(
  parameter int regCount = 16
) (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::regIdx_t rdIdxA,
  input  cpuPkg::regIdx_t rdIdxB,
  input  cpuPkg::regIdx_t rdIdxC,
  output cpuPkg::word_t   opA,      // Registered read ports
  output cpuPkg::word_t   opB,
  output cpuPkg::word_t   opC,
  output cpuPkg::word_t   stackPtr, // r0
  output cpuPkg::word_t   flags,    // r1
  input  logic            wrEn,
  input  cpuPkg::regIdx_t wrIdx,
  input  cpuPkg::word_t   wrData,
  input  logic            flagWrEn,
  input  cpuPkg::word_t   flagData,
  input  cpuPkg::word_t   spDelta,
  input  logic            spEn
);

  localparam int idxBits = $clog2(regCount);

  cpuPkg::word_t regs [regCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) regs[i] <= '0;
    end else begin
      if (spEn) regs[0] <= regs[0] + spDelta;
      if (flagWrEn) regs[1] <= flagData;
      // Last assignment wins, so a pop into r0 beats the sp step
      if (wrEn) regs[wrIdx[idxBits-1:0]] <= wrData;
    end
  end

  // Sampled every cycle, stable from decode until writeback
  always_ff @(posedge clk) begin
    opA <= regs[rdIdxA[idxBits-1:0]];
    opB <= regs[rdIdxB[idxBits-1:0]];
    opC <= regs[rdIdxC[idxBits-1:0]];
  end

  assign stackPtr = regs[0];
  assign flags    = regs[1];

endmodule

// ==== hw/executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit #(
  parameter int regCount = 16
) (
  input  cpuPkg::instr_t   instr,
  input  cpuPkg::word_t    opA,      // regA operand
  input  cpuPkg::word_t    opB,      // regB operand
  input  cpuPkg::word_t    opC,      // regC operand
  input  cpuPkg::word_t    stackPtr,
  input  cpuPkg::word_t    flags,
  input  cpuPkg::word_t    loadWord, // Data from the last read
  input  cpuPkg::addr_t    ipointer,
  output cpuPkg::exeOut_t  exe
);

  localparam cpuPkg::regIdx_t idxMask = cpuPkg::regIdx_t'(regCount - 1);

  cpuPkg::word_t k;        // Constant word
  cpuPkg::addr_t ipStep;   // Fall-through address
  cpuPkg::word_t cmpFlags;
  logic          taken;

  assign k      = instr.constWord;
  assign ipStep = ipointer + (instr.needsWord ? 32'd8 : 32'd4); // 8-byte forms skip the constant

  // Unsigned compare against the constant
  assign cmpFlags = {29'd0, opA > k, opA < k, opA == k};

  // Branch decision
  always_comb begin
    case (instr.opcode)
      cpuPkg::JmpC: taken = 1'b1;
      cpuPkg::JeC:  taken = flags[0];
      cpuPkg::JneC: taken = !flags[0];
      cpuPkg::JzRC: taken = (opC == '0); // Tested register sits in byte 3
      default:      taken = 1'b0;
    endcase
  end

  always_comb begin
    exe           = '0;
    exe.destIdx   = instr.regA & idxMask; // Destination is always regA
    exe.flagData  = cmpFlags;
    exe.nextIp    = taken ? k : ipStep;
    exe.storeData = opB;
    exe.memAddr   = opB + k;
    case (instr.opcode)
      cpuPkg::MovRC: begin
        exe.destWrEn = 1'b1;
        exe.destData = k;
      end
      cpuPkg::MovRR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB;
      end
      cpuPkg::AddRRR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB + opC;
      end
      cpuPkg::AddRRC: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB + k;
      end
      cpuPkg::SubRRR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB - opC;
      end
      cpuPkg::ShlRRR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB << opC;
      end
      cpuPkg::ShrRRR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opB >> opC; // Logical shift
      end
      cpuPkg::IncR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opA + 32'd1;
      end
      cpuPkg::DecR: begin
        exe.destWrEn = 1'b1;
        exe.destData = opA - 32'd1;
      end
      cpuPkg::CmpRC: exe.flagWrEn = 1'b1;
      cpuPkg::MovRdRo: begin
        exe.destWrEn = 1'b1;
        exe.destData = loadWord; // Address is base regB plus offset
      end
      cpuPkg::MovdRoR: begin
        exe.memAddr   = opA + k; // Base in regA, value in regB
        exe.storeData = opB;
      end
      cpuPkg::PushR: begin
        exe.memAddr   = stackPtr; // Stack grows upward
        exe.storeData = opA;
        exe.spDelta   = 32'd4;
      end
      cpuPkg::PopR: begin
        exe.memAddr  = stackPtr - 32'd4;
        exe.destWrEn = 1'b1;
        exe.destData = loadWord;
        exe.spDelta  = 32'hffff_fffc; // -4
      end
      cpuPkg::CallR: begin
        exe.memAddr   = stackPtr;
        exe.storeData = ipointer; // Own address, Ret adds 4
        exe.spDelta   = 32'd4;
        exe.nextIp    = opA;
      end
      cpuPkg::Ret: begin
        exe.memAddr = stackPtr - 32'd4;
        exe.spDelta = 32'hffff_fffc;
        exe.nextIp  = loadWord + 32'd4; // Resume after the call
      end
      cpuPkg::DoutR: exe.storeData = opA;
      cpuPkg::Stall: begin
        exe.halt   = 1'b1;
        exe.nextIp = ipointer; // IP parks on the Stall
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hw/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::exeOut_t exe,
  output cpuPkg::instr_t  instr,
  output cpuPkg::addr_t   ipointer,
  output logic            reqStart,
  output cpuPkg::addr_t   reqAddr,
  output logic            reqWrite,
  output cpuPkg::word_t   reqData,
  input  logic            reqDone,
  input  cpuPkg::word_t   readWord,
  output logic            wrEn,      // Writeback strobes
  output logic            flagWrEn,
  output logic            spEn,
  output logic            doutValid,
  output cpuPkg::word_t   doutData,
  output logic            halted
);

  cpuPkg::seqState_e state;
  cpuPkg::opcode_e   fetchOp;
  logic              fetchNeedsWord;
  cpuPkg::memKind_e  fetchMemKind;
  logic              isWrite;
  logic              moveSp;

  assign fetchOp = cpuPkg::opcode_e'(readWord[7:0]); // Opcode in byte 0

  // Instruction class from the fetched opcode
  always_comb begin
    fetchNeedsWord = 1'b0;
    fetchMemKind   = cpuPkg::none;
    case (fetchOp)
      cpuPkg::MovRC, cpuPkg::AddRRC, cpuPkg::CmpRC, cpuPkg::JmpC,
      cpuPkg::JeC, cpuPkg::JneC, cpuPkg::JzRC: fetchNeedsWord = 1'b1;
      cpuPkg::MovRdRo: begin
        fetchNeedsWord = 1'b1;
        fetchMemKind   = cpuPkg::load;
      end
      cpuPkg::MovdRoR: begin
        fetchNeedsWord = 1'b1;
        fetchMemKind   = cpuPkg::store;
      end
      cpuPkg::PushR: fetchMemKind = cpuPkg::push;
      cpuPkg::PopR:  fetchMemKind = cpuPkg::pop;
      cpuPkg::CallR: fetchMemKind = cpuPkg::call;
      cpuPkg::Ret:   fetchMemKind = cpuPkg::ret;
      default: begin
      end
    endcase
  end

  assign isWrite = instr.memKind inside {cpuPkg::store, cpuPkg::push, cpuPkg::call};
  assign moveSp  = instr.memKind inside {cpuPkg::push, cpuPkg::pop, cpuPkg::call, cpuPkg::ret};

  // Bus request for the current state
  always_comb begin
    reqStart = 1'b0;
    reqAddr  = ipointer;
    reqWrite = 1'b0;
    reqData  = exe.storeData;
    case (state)
      cpuPkg::fetchReq: reqStart = 1'b1;
      cpuPkg::wordReq: begin
        reqStart = 1'b1;
        reqAddr  = ipointer + 32'd4; // Constant follows the opcode word
      end
      cpuPkg::memReq: begin
        reqStart = 1'b1;
        reqAddr  = exe.memAddr;
        reqWrite = isWrite;
      end
      default: begin
      end
    endcase
  end

  assign wrEn     = (state == cpuPkg::writeback) && exe.destWrEn;
  assign flagWrEn = (state == cpuPkg::writeback) && exe.flagWrEn;
  assign spEn     = (state == cpuPkg::writeback) && moveSp;
  assign halted   = (state == cpuPkg::halted);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= cpuPkg::fetchReq;
      ipointer  <= '0;
      instr     <= '0;
      doutValid <= 1'b0;
    end else begin
      doutValid <= 1'b0;
      case (state)
        cpuPkg::fetchReq: state <= cpuPkg::fetchWait;
        cpuPkg::fetchWait: if (reqDone) begin
          instr.opcode    <= fetchOp;
          instr.regA      <= readWord[15:8];
          instr.regB      <= readWord[23:16];
          instr.regC      <= readWord[31:24];
          instr.constWord <= '0;
          instr.needsWord <= fetchNeedsWord;
          instr.memKind   <= fetchMemKind;
          state           <= cpuPkg::decode;
        end
        cpuPkg::decode: begin
          if (instr.needsWord) state <= cpuPkg::wordReq;
          else if (instr.memKind != cpuPkg::none) state <= cpuPkg::memReq;
          else state <= cpuPkg::writeback;
        end
        cpuPkg::wordReq: state <= cpuPkg::wordWait;
        cpuPkg::wordWait: if (reqDone) begin
          instr.constWord <= readWord;
          state <= (instr.memKind != cpuPkg::none) ? cpuPkg::memReq : cpuPkg::writeback;
        end
        cpuPkg::memReq: state <= cpuPkg::memWait;
        cpuPkg::memWait: if (reqDone) state <= cpuPkg::writeback;
        cpuPkg::writeback: begin
          ipointer  <= exe.nextIp;
          doutValid <= (instr.opcode == cpuPkg::DoutR); // One-cycle pulse
          state     <= exe.halt ? cpuPkg::halted : cpuPkg::fetchReq;
        end
        cpuPkg::halted: state <= cpuPkg::halted; // Only reset leaves
        default: state <= cpuPkg::fetchReq;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cpuPkg::writeback) doutData <= exe.storeData; // Paired with doutValid
  end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop #(
  parameter int regCount = 16
) (
  input  logic           clk,
  input  logic           reset,
  output cpuPkg::wbReq_t wbOut,
  input  cpuPkg::wbRsp_t wbIn,
  output logic           doutValid,
  output cpuPkg::word_t  doutData,
  output logic           halted
);

  cpuPkg::instr_t  instr;
  cpuPkg::addr_t   ipointer;
  cpuPkg::exeOut_t exe;
  logic            reqStart;
  cpuPkg::addr_t   reqAddr;
  logic            reqWrite;
  cpuPkg::word_t   reqData;
  logic            reqDone;
  cpuPkg::word_t   readWord; // Also the load word for execute
  cpuPkg::word_t   opA;
  cpuPkg::word_t   opB;
  cpuPkg::word_t   opC;
  cpuPkg::word_t   stackPtr;
  cpuPkg::word_t   flags;
  logic            wrEn;
  logic            flagWrEn;
  logic            spEn;

  controlSequencer seq (
    .clk(clk), .reset(reset), .exe(exe), .instr(instr), .ipointer(ipointer),
    .reqStart(reqStart), .reqAddr(reqAddr), .reqWrite(reqWrite), .reqData(reqData),
    .reqDone(reqDone), .readWord(readWord), .wrEn(wrEn), .flagWrEn(flagWrEn),
    .spEn(spEn), .doutValid(doutValid), .doutData(doutData), .halted(halted)
  );

  registerFile #(.regCount(regCount)) regFile (
    .clk(clk), .reset(reset), .rdIdxA(instr.regA), .rdIdxB(instr.regB),
    .rdIdxC(instr.regC), .opA(opA), .opB(opB), .opC(opC), .stackPtr(stackPtr),
    .flags(flags), .wrEn(wrEn), .wrIdx(exe.destIdx), .wrData(exe.destData),
    .flagWrEn(flagWrEn), .flagData(exe.flagData), .spDelta(exe.spDelta), .spEn(spEn)
  );

  executeUnit #(.regCount(regCount)) exeUnit (
    .instr(instr), .opA(opA), .opB(opB), .opC(opC), .stackPtr(stackPtr),
    .flags(flags), .loadWord(readWord), .ipointer(ipointer), .exe(exe)
  );

  busMaster bus (
    .clk(clk), .reset(reset), .reqStart(reqStart), .reqAddr(reqAddr),
    .reqWrite(reqWrite), .reqData(reqData), .wbOut(wbOut), .wbIn(wbIn),
    .reqDone(reqDone), .readWord(readWord)
  );

endmodule

// ==== dv/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Word index of a byte address in the 1024-word memory
function automatic int wordIdx(input cpuPkg::addr_t a);
  return int'(a[11:2]);
endfunction

function automatic cpuPkg::word_t enc(input cpuPkg::opcode_e op, input int a, input int b,
                                      input int c);
  return {c[7:0], b[7:0], a[7:0], op}; // Byte 0 opcode then regA, regB and regC
endfunction

task automatic putWord(inout int p, input cpuPkg::word_t w);
  image[p] = w;
  p++;
endtask

// 8-byte form with its constant in the next word
task automatic putWithConst(inout int p, input cpuPkg::word_t w, input cpuPkg::word_t k);
  putWord(p, w);
  putWord(p, k);
endtask

// Test program with code at 0, subroutine at 0x200, data at 0x600 and stack at 0x800
task automatic buildImage();
  int p;
  for (int i = 0; i < 1024; i++) image[i] = 32'hc0de_0000 ^ (i << 2); // Address-tagged fill
  p = 0;
  putWithConst(p, enc(cpuPkg::MovRC, 0, 0, 0), 32'h800); // 0x00 sp
  putWithConst(p, enc(cpuPkg::MovRC, 2, 0, 0), 32'd7);
  putWithConst(p, enc(cpuPkg::MovRC, 3, 0, 0), 32'd5);
  putWord(p, enc(cpuPkg::AddRRR, 4, 2, 3)); // 0x18
  putWord(p, enc(cpuPkg::DoutR, 4, 0, 0));
  putWord(p, enc(cpuPkg::SubRRR, 5, 2, 3));
  putWord(p, enc(cpuPkg::DoutR, 5, 0, 0));
  putWord(p, enc(cpuPkg::ShlRRR, 6, 2, 3));
  putWord(p, enc(cpuPkg::DoutR, 6, 0, 0));
  putWord(p, enc(cpuPkg::ShrRRR, 7, 6, 5));
  putWord(p, enc(cpuPkg::DoutR, 7, 0, 0));
  putWithConst(p, enc(cpuPkg::AddRRC, 8, 2, 0), 32'h100); // 0x38
  putWord(p, enc(cpuPkg::DoutR, 8, 0, 0));
  putWord(p, enc(cpuPkg::MovRR, 9, 8, 0));
  putWord(p, enc(cpuPkg::IncR, 9, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 9, 0, 0));
  putWord(p, enc(cpuPkg::DecR, 3, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 3, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 3, 0, 0)); // 0x58 countdown loop
  putWord(p, enc(cpuPkg::DecR, 3, 0, 0));
  putWithConst(p, enc(cpuPkg::CmpRC, 3, 0, 0), 32'd2);
  putWithConst(p, enc(cpuPkg::JeC, 0, 0, 0), 32'h78);
  putWithConst(p, enc(cpuPkg::JmpC, 0, 0, 0), 32'h58);
  putWithConst(p, enc(cpuPkg::CmpRC, 3, 0, 0), 32'd9); // 0x78
  putWithConst(p, enc(cpuPkg::JneC, 0, 0, 0), 32'h90);
  putWord(p, enc(cpuPkg::Stall, 0, 0, 0)); // Skipped
  putWord(p, enc(cpuPkg::DoutR, 2, 0, 0)); // Skipped
  putWithConst(p, enc(cpuPkg::JzRC, 0, 0, 3), 32'h88); // 0x90 not taken
  putWithConst(p, enc(cpuPkg::MovRC, 3, 0, 0), 32'd0);
  putWithConst(p, enc(cpuPkg::JzRC, 0, 0, 3), 32'hb0); // Taken
  putWord(p, enc(cpuPkg::Stall, 0, 0, 0));
  putWord(p, enc(cpuPkg::Stall, 0, 0, 0));
  putWithConst(p, enc(cpuPkg::MovRC, 10, 0, 0), 32'h600); // 0xb0
  putWithConst(p, enc(cpuPkg::MovdRoR, 10, 2, 0), 32'h8);
  putWithConst(p, enc(cpuPkg::MovdRoR, 10, 8, 0), 32'hc);
  putWithConst(p, enc(cpuPkg::MovRdRo, 11, 10, 0), 32'h8);
  putWord(p, enc(cpuPkg::DoutR, 11, 0, 0));
  putWithConst(p, enc(cpuPkg::MovRdRo, 12, 10, 0), 32'hc);
  putWord(p, enc(cpuPkg::DoutR, 12, 0, 0));
  putWord(p, enc(cpuPkg::PushR, 4, 0, 0)); // 0xe0
  putWord(p, enc(cpuPkg::PushR, 5, 0, 0));
  putWithConst(p, enc(cpuPkg::MovRC, 13, 0, 0), 32'h200);
  putWord(p, enc(cpuPkg::CallR, 13, 0, 0)); // 0xf0
  putWord(p, enc(cpuPkg::PopR, 14, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 14, 0, 0));
  putWord(p, enc(cpuPkg::PopR, 15, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 15, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 0, 0, 0));
  putWord(p, enc(cpuPkg::Stall, 0, 0, 0));
  p = 32'h200 >> 2; // Subroutine
  putWord(p, enc(cpuPkg::IncR, 4, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 4, 0, 0));
  putWord(p, enc(cpuPkg::DoutR, 1, 0, 0)); // Less flag from the compare at 0x78
  putWithConst(p, enc(cpuPkg::CmpRC, 4, 0, 0), 32'd5);
  putWord(p, enc(cpuPkg::DoutR, 1, 0, 0)); // Greater flag
  putWord(p, enc(cpuPkg::Ret, 0, 0, 0));
endtask

// Executes one instruction on the model state and returns 1 on Stall
function automatic bit refStep();
  cpuPkg::word_t w;
  cpuPkg::word_t k;
  cpuPkg::word_t a;
  cpuPkg::word_t b;
  cpuPkg::word_t c;
  cpuPkg::word_t v;
  cpuPkg::word_t sp;
  cpuPkg::opcode_e op;
  cpuPkg::addr_t nip;
  int ra;
  int rb;
  w  = refMem[wordIdx(refIp)];
  k  = refMem[wordIdx(refIp + 32'd4)];
  op = cpuPkg::opcode_e'(w[7:0]);
  ra = int'(w[11:8]); // Low 4 bits index 16 registers
  rb = int'(w[19:16]);
  a  = refReg[ra];
  b  = refReg[rb];
  c  = refReg[w[27:24]];
  sp = refReg[0];
  nip = refIp + ((op inside {cpuPkg::MovRC, cpuPkg::AddRRC, cpuPkg::CmpRC, cpuPkg::JmpC,
                 cpuPkg::JeC, cpuPkg::JneC, cpuPkg::JzRC, cpuPkg::MovRdRo,
                 cpuPkg::MovdRoR}) ? 32'd8 : 32'd4);
  case (op)
    cpuPkg::MovRC:  refReg[ra] = k;
    cpuPkg::MovRR:  refReg[ra] = b;
    cpuPkg::AddRRR: refReg[ra] = b + c;
    cpuPkg::AddRRC: refReg[ra] = b + k;
    cpuPkg::SubRRR: refReg[ra] = b - c;
    cpuPkg::ShlRRR: refReg[ra] = b << c;
    cpuPkg::ShrRRR: refReg[ra] = b >> c;
    cpuPkg::IncR:   refReg[ra] = a + 32'd1;
    cpuPkg::DecR:   refReg[ra] = a - 32'd1;
    cpuPkg::CmpRC:  refReg[1] = {29'd0, a > k, a < k, a == k};
    cpuPkg::JmpC:   nip = k;
    cpuPkg::JeC:    if (refReg[1][0]) nip = k;
    cpuPkg::JneC:   if (!refReg[1][0]) nip = k;
    cpuPkg::JzRC:   if (c == 0) nip = k;
    cpuPkg::MovRdRo: refReg[ra] = refMem[wordIdx(b + k)];
    cpuPkg::MovdRoR: begin
      refMem[wordIdx(a + k)] = b;
      expAddr.push_back(a + k);
      expData.push_back(b);
    end
    cpuPkg::PushR, cpuPkg::CallR: begin
      v = (op == cpuPkg::PushR) ? a : refIp; // Call saves its own address
      refMem[wordIdx(sp)] = v;
      expAddr.push_back(sp);
      expData.push_back(v);
      refReg[0] = sp + 32'd4;
      if (op == cpuPkg::CallR) nip = a;
    end
    cpuPkg::PopR, cpuPkg::Ret: begin
      v = refMem[wordIdx(sp - 32'd4)];
      refReg[0] = sp - 32'd4;
      if (op == cpuPkg::PopR) refReg[ra] = v; // Destination beats sp step
      else nip = v + 32'd4;
    end
    cpuPkg::DoutR: expDout.push_back(a);
    cpuPkg::Stall: return 1'b1;
    default: ;
  endcase
  refIp = nip;
  return 1'b0;
endfunction

`endif

// ==== dv/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;

  logic           clk;
  logic           reset;
  cpuPkg::wbReq_t wbOut;
  cpuPkg::wbRsp_t wbIn;
  logic           doutValid;
  cpuPkg::word_t  doutData;
  logic           halted;

  cpuPkg::word_t image [1024];
  cpuPkg::word_t mem [1024];    // Slave memory
  cpuPkg::word_t refMem [1024]; // Model memory
  cpuPkg::word_t refReg [16];
  cpuPkg::addr_t refIp;
  cpuPkg::addr_t expAddr [$];
  cpuPkg::word_t expData [$];
  cpuPkg::word_t expDout [$];

  integer seed;
  int     waitCnt;
  bit     zeroDelay;
  bit     firstSeen;
  bit     running;
  int     cycles;
  int     limit;
  int     steps;

  `include "isaModel.svh"

  cpuTop #(.regCount(16)) UUT (
    .clk(clk), .reset(reset), .wbOut(wbOut), .wbIn(wbIn),
    .doutValid(doutValid), .doutData(doutData), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkAddr(input cpuPkg::addr_t got, input cpuPkg::addr_t exp, input string what);
    if (got !== exp)
      abortRun($sformatf("Fail at %0t: %s address %h expected %h", $time, what, got, exp));
  endtask

  task automatic checkWord(input cpuPkg::word_t got, input cpuPkg::word_t exp, input string what);
    if (got !== exp)
      abortRun($sformatf("Fail at %0t: %s data %h expected %h", $time, what, got, exp));
  endtask

  // True once every expected store and output has been seen
  function automatic bit drained();
    return expAddr.size() == 0 && expData.size() == 0 && expDout.size() == 0;
  endfunction

  // Wishbone slave acking after 0 to 3 wait cycles
  always @(posedge clk) begin
    wbIn.ack <= 1'b0;
    if (reset) begin
      waitCnt <= 0;
    end else if (wbOut.cyc && wbOut.stb && !wbIn.ack) begin
      if (waitCnt == 0) begin
        wbIn.ack  <= 1'b1;
        wbIn.datR <= mem[wordIdx(wbOut.adr)];
        if (wbOut.we) mem[wordIdx(wbOut.adr)] = wbOut.datW;
        waitCnt <= zeroDelay ? 0 : ($random(seed) & 3);
      end else begin
        waitCnt <= waitCnt - 1;
      end
    end
  end

  // Compare on the falling edge where DUT outputs are settled
  always @(negedge clk) begin
    if (reset) begin
      firstSeen = 1'b0;
      if (wbOut.cyc || wbOut.stb || doutValid || halted)
        abortRun("Bus or status outputs were not low during reset");
    end else begin
      if (wbOut.cyc && !firstSeen) begin
        firstSeen = 1'b1;
        checkAddr(wbOut.adr, 32'h0, "first fetch");
        if (wbOut.we) abortRun("First bus request after reset was a write");
      end
      if (halted && wbOut.cyc) abortRun("Bus cycle started after halt");
      if (wbOut.cyc && wbOut.we && wbIn.ack) begin
        if (expAddr.size() == 0) abortRun("Bus write with no store expected");
        checkAddr(wbOut.adr, expAddr.pop_front(), "store");
        checkWord(wbOut.datW, expData.pop_front(), "store");
      end
      if (doutValid) begin
        if (halted) abortRun("Debug output pulse after halt");
        if (expDout.size() == 0) abortRun("Debug output with no value expected");
        checkWord(doutData, expDout.pop_front(), "dout");
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    if (running) begin
      cycles++;
      if (cycles > limit) abortRun("Watchdog expired before the core halted");
    end
  end

  initial begin
    seed    = 32'h7cd4_7a2b;
    reset   <= 1'b1;
    wbIn    <= '0;
    waitCnt <= 0;
    running = 1'b0;
    cycles  = 0;
    limit   = 0;
    for (int run = 0; run < 2; run++) begin
      zeroDelay = (run == 0); // Second run uses random ack delays
      buildImage();
      mem    = image;
      refMem = image;
      refIp  = '0;
      for (int i = 0; i < 16; i++) refReg[i] = '0;
      expAddr.delete();
      expData.delete();
      expDout.delete();
      steps = 1;
      while (!refStep()) steps++;
      @(posedge clk);
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      cycles  = 0;
      limit   = steps * 40;
      running = 1'b1;
      wait (halted);
      running = 1'b0;
      repeat (20) @(negedge clk); // Idle window for the cyc check after halt
      if (run == 0 && !drained())
        abortRun("Core halted with expected stores or outputs still missing");
    end
    if (!drained()) begin
      abortRun("Core halted with expected stores or outputs still missing");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== all.f ====
+incdir+dv
hw/cpuPkg.sv
hw/busMaster.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/controlSequencer.sv
hw/cpuTop.sv
dv/cpuTb.sv

// ==== Makefile ====
SRCS = hw/cpuPkg.sv hw/busMaster.sv hw/registerFile.sv hw/executeUnit.sv \
       hw/controlSequencer.sv hw/cpuTop.sv dv/cpuTb.sv dv/isaModel.svh

.PHONY: all run clean

all: obj_dir/VcpuTb

obj_dir/VcpuTb: all.f $(SRCS)
	verilator --binary --timing -f all.f --top-module cpuTb -Mdir obj_dir -o VcpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb

clean:
	rm -rf obj_dir
